// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_channel_buffer
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== buffer_control.sv ====
`timescale 1ns/1ps

module buffer_control #(
    parameter int IMAGE_WIDTH  = 26,
    parameter int IMAGE_HEIGHT = 34
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_in,
    output logic                           wr_en_even,
    output logic                           wr_en_odd,
    output logic                           wr_col_odd,
    output channel_buffer_pkg::addr_t      wr_addr,
    output logic                           rd_en,
    output channel_buffer_pkg::addr_t      rd_addr,
    output channel_buffer_pkg::win_index_t rd_index,
    output logic                           rd_last,
    output logic                           reading
);

    localparam int BLOCKS_PER_ROW = IMAGE_WIDTH / 2;
    localparam int NUM_WINDOWS    = (IMAGE_HEIGHT / 2) * BLOCKS_PER_ROW;
    localparam int ROW_BITS       = $clog2(IMAGE_HEIGHT);
    localparam int COL_BITS       = $clog2(IMAGE_WIDTH);

    localparam channel_buffer_pkg::win_index_t LAST_INDEX =
        channel_buffer_pkg::win_index_t'(NUM_WINDOWS - 1);

    channel_buffer_pkg::ctrl_state_e state;

    logic [ROW_BITS-1:0] row_cnt;
    logic [COL_BITS-1:0] col_cnt;
    logic                accept;
    logic                col_end;
    logic                row_end;

    assign accept  = valid_in && (state == channel_buffer_pkg::FILL);
    assign col_end = (col_cnt == COL_BITS'(IMAGE_WIDTH - 1));
    assign row_end = (row_cnt == ROW_BITS'(IMAGE_HEIGHT - 1));

    // row parity picks the bank, column parity the half of the word
    assign wr_en_even = accept && !row_cnt[0];
    assign wr_en_odd  = accept && row_cnt[0];
    assign wr_col_odd = col_cnt[0];

    assign wr_addr = channel_buffer_pkg::addr_t'(row_cnt >> 1)
                   * channel_buffer_pkg::addr_t'(BLOCKS_PER_ROW)
                   + channel_buffer_pkg::addr_t'(col_cnt >> 1);

    // window index doubles as the bank address
    assign rd_addr = channel_buffer_pkg::addr_t'(rd_index);
    assign rd_last = rd_en && (rd_index == LAST_INDEX);
    assign reading = (state == channel_buffer_pkg::DRAIN);

    // raster capture and fill/drain state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= channel_buffer_pkg::FILL;
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (accept) begin
            if (col_end) begin
                col_cnt <= '0;
                if (row_end) begin
                    row_cnt <= '0;
                    state   <= channel_buffer_pkg::DRAIN;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end else if (rd_last) begin
            state <= channel_buffer_pkg::FILL;
        end
    end

    // block scan, first read one cycle after drain starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en    <= 1'b0;
            rd_index <= '0;
        end else if (state == channel_buffer_pkg::DRAIN) begin
            if (!rd_en) begin
                rd_en <= 1'b1;
            end else if (rd_last) begin
                rd_en    <= 1'b0;
                rd_index <= '0;
            end else begin
                rd_index <= rd_index + 1'b1;
            end
        end
    end

endmodule

// ==== channel_buffer.sv ====
`timescale 1ns/1ps

module channel_buffer #(
    parameter int IMAGE_WIDTH  = 26,
    parameter int IMAGE_HEIGHT = 34,
    parameter int CHANNELS     = 32
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       valid_in,
    input  channel_buffer_pkg::pixel_t [CHANNELS-1:0]  data_in,
    output logic                                       valid_out,
    output channel_buffer_pkg::window_t [CHANNELS-1:0] window_out,
    output channel_buffer_pkg::win_index_t             window_index,
    output logic                                       frame_done,
    output logic                                       reading
);

    logic                                           wr_en_even;
    logic                                           wr_en_odd;
    logic                                           wr_col_odd;
    channel_buffer_pkg::addr_t                      wr_addr;
    logic                                           rd_en;
    channel_buffer_pkg::addr_t                      rd_addr;
    channel_buffer_pkg::win_index_t                 rd_index;
    logic                                           rd_last;
    channel_buffer_pkg::pixel_pair_t [CHANNELS-1:0] even_pair;
    channel_buffer_pkg::pixel_pair_t [CHANNELS-1:0] odd_pair;

    buffer_control #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT)
    ) u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .wr_en_even (wr_en_even),
        .wr_en_odd  (wr_en_odd),
        .wr_col_odd (wr_col_odd),
        .wr_addr    (wr_addr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_index   (rd_index),
        .rd_last    (rd_last),
        .reading    (reading)
    );

    // top row of each window
    line_bank #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .CHANNELS     (CHANNELS)
    ) even_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en_even),
        .wr_col_odd (wr_col_odd),
        .wr_addr    (wr_addr),
        .wr_data    (data_in),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pair    (even_pair)
    );

    // bottom row of each window
    line_bank #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .CHANNELS     (CHANNELS)
    ) odd_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en_odd),
        .wr_col_odd (wr_col_odd),
        .wr_addr    (wr_addr),
        .wr_data    (data_in),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pair    (odd_pair)
    );

    window_assembler #(
        .CHANNELS (CHANNELS)
    ) u_assembler (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .rd_last      (rd_last),
        .rd_index     (rd_index),
        .top_pair     (even_pair),
        .bottom_pair  (odd_pair),
        .valid_out    (valid_out),
        .window_out   (window_out),
        .window_index (window_index),
        .frame_done   (frame_done)
    );

endmodule

// ==== channel_buffer_pkg.sv ====
package channel_buffer_pkg;

    localparam int PIXEL_BITS = 32;
    localparam int ADDR_BITS  = 10;
    localparam int INDEX_BITS = 11;

    // one channel sample
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // bank word, block row * blocks per row + block column
    typedef logic [ADDR_BITS-1:0] addr_t;

    // window number within a frame
    typedef logic [INDEX_BITS-1:0] win_index_t;

    // even column in left, odd column in right
    typedef struct packed {
        pixel_t left;
        pixel_t right;
    } pixel_pair_t;

    typedef struct packed {
        pixel_t top_left;
        pixel_t top_right;
        pixel_t bottom_left;
        pixel_t bottom_right;
    } window_t;

    typedef enum logic {
        FILL  = 1'b0,
        DRAIN = 1'b1
    } ctrl_state_e;

endpackage

// ==== line_bank.sv ====
`timescale 1ns/1ps

module line_bank #(
    parameter int IMAGE_WIDTH  = 26,
    parameter int IMAGE_HEIGHT = 34,
    parameter int CHANNELS     = 32
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        wr_en,
    input  logic                                        wr_col_odd,
    input  channel_buffer_pkg::addr_t                   wr_addr,
    input  channel_buffer_pkg::pixel_t [CHANNELS-1:0]   wr_data,
    input  logic                                        rd_en,
    input  channel_buffer_pkg::addr_t                   rd_addr,
    output channel_buffer_pkg::pixel_pair_t [CHANNELS-1:0] rd_pair
);

    localparam int DEPTH = (IMAGE_HEIGHT / 2) * (IMAGE_WIDTH / 2);
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // one word holds the pixel of every channel at a block position
    channel_buffer_pkg::pixel_t [CHANNELS-1:0] even_col_mem [DEPTH];
    channel_buffer_pkg::pixel_t [CHANNELS-1:0] odd_col_mem  [DEPTH];

    logic [AW-1:0] wr_word;
    logic [AW-1:0] rd_word;

    assign wr_word = wr_addr[AW-1:0];
    assign rd_word = rd_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_col_odd) begin
                odd_col_mem[wr_word] <= wr_data;
            end else begin
                even_col_mem[wr_word] <= wr_data;
            end
        end
    end

    // both columns of the block come out together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pair <= '0;
        end else if (rd_en) begin
            for (int c = 0; c < CHANNELS; c++) begin
                rd_pair[c].left  <= even_col_mem[rd_word][c];
                rd_pair[c].right <= odd_col_mem[rd_word][c];
            end
        end
    end

endmodule

// ==== list.f ====
channel_buffer_pkg.sv
buffer_control.sv
line_bank.sv
window_assembler.sv
channel_buffer.sv
tb_channel_buffer.sv

// ==== tb_channel_buffer.sv ====
`timescale 1ns/1ps

module tb_channel_buffer;

    localparam int IMAGE_WIDTH  = 6;
    localparam int IMAGE_HEIGHT = 4;
    localparam int CHANNELS     = 4;
    localparam int PIXELS       = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int NUM_WINDOWS  = (IMAGE_HEIGHT / 2) * (IMAGE_WIDTH / 2);
    localparam int NUM_SLOTS    = 5;
    localparam int WAIT_LIMIT   = 200;

    localparam channel_buffer_pkg::win_index_t LAST_INDEX =
        channel_buffer_pkg::win_index_t'(NUM_WINDOWS - 1);

    logic                                       clk;
    logic                                       rst_n;
    logic                                       valid_in;
    channel_buffer_pkg::pixel_t [CHANNELS-1:0]  data_in;
    logic                                       valid_out;
    channel_buffer_pkg::window_t [CHANNELS-1:0] window_out;
    channel_buffer_pkg::win_index_t             window_index;
    logic                                       frame_done;
    logic                                       reading;

    // frame model with one slot per frame sent
    channel_buffer_pkg::pixel_t frames [NUM_SLOTS][IMAGE_HEIGHT][IMAGE_WIDTH][CHANNELS];

    int slot_queue [$];
    int mismatch_count;
    int other_count;
    int frames_checked;
    int windows_checked;

    channel_buffer_pkg::win_index_t exp_index;
    int                             cur_slot;
    logic                           have_slot;

    channel_buffer #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .CHANNELS     (CHANNELS)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .data_in      (data_in),
        .valid_out    (valid_out),
        .window_out   (window_out),
        .window_index (window_index),
        .frame_done   (frame_done),
        .reading      (reading)
    );

    always #2 clk = ~clk;

    function automatic channel_buffer_pkg::window_t expected_window(int slot, int index, int ch);
        channel_buffer_pkg::window_t w;
        int r;
        int c;
        r = index / (IMAGE_WIDTH / 2);
        c = index % (IMAGE_WIDTH / 2);
        w.top_left     = frames[slot][2*r][2*c][ch];
        w.top_right    = frames[slot][2*r][2*c+1][ch];
        w.bottom_left  = frames[slot][2*r+1][2*c][ch];
        w.bottom_right = frames[slot][2*r+1][2*c+1][ch];
        return w;
    endfunction

    task automatic check_window(string name, channel_buffer_pkg::window_t got,
                                channel_buffer_pkg::window_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_index(string name, channel_buffer_pkg::win_index_t got,
                               channel_buffer_pkg::win_index_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic fill_frame(int slot);
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    frames[slot][r][c][ch] = $urandom();
                end
            end
        end
    endtask

    // raster order with random idle gaps from a falling edge
    task automatic send_pixels(int slot, int count, bit no_first_gap);
        int unsigned gap;
        int r;
        int c;
        for (int p = 0; p < count; p++) begin
            gap = (p == 0 && no_first_gap) ? 0 : $urandom_range(2, 0);
            repeat (gap) begin
                valid_in = 1'b0;
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    data_in[ch] = $urandom();
                end
                @(negedge clk);
            end
            r = p / IMAGE_WIDTH;
            c = p % IMAGE_WIDTH;
            valid_in = 1'b1;
            for (int ch = 0; ch < CHANNELS; ch++) begin
                data_in[ch] = frames[slot][r][c][ch];
            end
            @(negedge clk);
        end
        valid_in = 1'b0;
        if (count == PIXELS) begin
            slot_queue.push_back(slot);
        end
    endtask

    // strobes during readout that the DUT must drop
    task automatic send_ignored_strobes(int count);
        for (int i = 0; i < count; i++) begin
            check_flag("reading", reading, 1'b1);
            valid_in = 1'b1;
            for (int ch = 0; ch < CHANNELS; ch++) begin
                data_in[ch] = $urandom();
            end
            @(negedge clk);
        end
        valid_in = 1'b0;
    endtask

    task automatic wait_reading_low();
        int waited;
        waited = 0;
        while (reading !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reading !== 1'b0) begin
            $display("timeout: reading never fell after %0d cycles", WAIT_LIMIT);
            other_count++;
        end
    endtask

    task automatic wait_frames_checked(int count);
        int waited;
        waited = 0;
        while (frames_checked < count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (frames_checked < count) begin
            $display("timeout: only %0d of %0d frames were read out", frames_checked, count);
            other_count++;
        end
    endtask

    // scoreboard on every rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_index = '0;
            have_slot = 1'b0;
        end else if (valid_out === 1'b1) begin
            if (!have_slot) begin
                if (slot_queue.size() == 0) begin
                    $display("valid_out went high with no complete frame written");
                    other_count++;
                end else begin
                    cur_slot  = slot_queue.pop_front();
                    have_slot = 1'b1;
                end
            end
            if (have_slot) begin
                check_index("window_index", window_index, exp_index);
                check_flag("frame_done", frame_done, exp_index == LAST_INDEX);
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    check_window($sformatf("window_out[%0d]", ch), window_out[ch],
                                 expected_window(cur_slot, int'(exp_index), ch));
                end
                windows_checked++;
                if (exp_index == LAST_INDEX) begin
                    exp_index = '0;
                    have_slot = 1'b0;
                    frames_checked++;
                end else begin
                    exp_index = exp_index + 1'b1;
                end
            end
        end else begin
            check_flag("frame_done", frame_done, 1'b0);
            if (have_slot && exp_index != '0) begin
                $display("valid_out dropped in the middle of a frame at window %0d",
                         exp_index);
                other_count++;
            end
        end
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        valid_in        = 1'b0;
        data_in         = '0;
        mismatch_count  = 0;
        other_count     = 0;
        frames_checked  = 0;
        windows_checked = 0;
        exp_index       = '0;
        cur_slot        = 0;
        have_slot       = 1'b0;
        void'($urandom(32'h4c3f_275c));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            fill_frame(s);
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // quiet outputs before any pixel
        repeat (5) begin
            @(negedge clk);
            check_flag("valid_out", valid_out, 1'b0);
            check_flag("frame_done", frame_done, 1'b0);
            check_flag("reading", reading, 1'b0);
        end

        send_pixels(0, PIXELS, 1'b0);
        send_ignored_strobes(3);
        wait_reading_low();
        // starts while the last windows of frame 0 are still coming out
        send_pixels(1, PIXELS, 1'b1);
        send_ignored_strobes(2);
        wait_reading_low();
        send_pixels(2, PIXELS, 1'b0);
        wait_frames_checked(3);

        // half a frame that reset throws away
        send_pixels(3, PIXELS / 2, 1'b0);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        send_pixels(4, PIXELS, 1'b0);
        wait_frames_checked(4);
        repeat (6) @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures, %0d windows checked",
                 mismatch_count, other_count, windows_checked);
        if (mismatch_count == 0 && other_count == 0 && frames_checked == 4) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== window_assembler.sv ====
`timescale 1ns/1ps

module window_assembler #(
    parameter int CHANNELS = 32
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           rd_en,
    input  logic                                           rd_last,
    input  channel_buffer_pkg::win_index_t                 rd_index,
    input  channel_buffer_pkg::pixel_pair_t [CHANNELS-1:0] top_pair,
    input  channel_buffer_pkg::pixel_pair_t [CHANNELS-1:0] bottom_pair,
    output logic                                           valid_out,
    output channel_buffer_pkg::window_t [CHANNELS-1:0]     window_out,
    output channel_buffer_pkg::win_index_t                 window_index,
    output logic                                           frame_done
);

    logic                                       rd_en_d;
    logic                                       rd_last_d;
    channel_buffer_pkg::win_index_t             rd_index_d;
    channel_buffer_pkg::window_t [CHANNELS-1:0] window_next;

    // tags wait one cycle for the bank read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_d    <= 1'b0;
            rd_last_d  <= 1'b0;
            rd_index_d <= '0;
        end else begin
            rd_en_d    <= rd_en;
            rd_last_d  <= rd_last;
            rd_index_d <= rd_index;
        end
    end

    always_comb begin
        for (int c = 0; c < CHANNELS; c++) begin
            window_next[c].top_left     = top_pair[c].left;
            window_next[c].top_right    = top_pair[c].right;
            window_next[c].bottom_left  = bottom_pair[c].left;
            window_next[c].bottom_right = bottom_pair[c].right;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            frame_done   <= 1'b0;
            window_index <= '0;
        end else begin
            valid_out  <= rd_en_d;
            frame_done <= rd_en_d && rd_last_d;
            if (rd_en_d) begin
                window_index <= rd_index_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_d) begin
            window_out <= window_next;
        end
    end

endmodule
